//--- hdl/rv32_pkg.sv
/* RV32 base definitions shared by the core and the extensions.
   Holds the data word, the decoded instruction views and the opcodes. */
`default_nettype none

package rv32_pkg;

  // Data word of the register file and the datapath
  typedef logic [31:0] word_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  // One instruction word, read as R-format or as I-format
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } insn_u;

  localparam logic [6:0] OP_IMM     = 7'b0010011;
  localparam logic [6:0] OP_REG     = 7'b0110011;
  localparam logic [6:0] OP_CUSTOM0 = 7'b0001011;
  localparam logic [6:0] OP_CUSTOM1 = 7'b0101011;

  // funct3 shared by add and addi
  localparam logic [2:0] F3_ADD = 3'b000;

endpackage

`default_nettype wire

//--- hdl/rmgmt_pkg.sv
/* Extension manager definitions: extension numbering, custom funct3
   codes and the exception cause encoding seen at the top level. */
`default_nettype none

package rmgmt_pkg;

  // Number of attached extensions and the width of an index
  localparam int N_EXT    = 2;
  localparam int EXT_BITS = 1;

  // Slot of each extension in the per-extension arrays
  localparam logic [EXT_BITS-1:0] EXT_MUL    = 1'd0;
  localparam logic [EXT_BITS-1:0] EXT_BITOPS = 1'd1;

  // custom-0 function
  localparam logic [2:0] F3_MUL = 3'd0;

  // custom-1 functions
  localparam logic [2:0] F3_POPC = 3'd0;
  localparam logic [2:0] F3_CLZ  = 3'd1;

  // Exception cause
  // Extension exceptions report the extension index
  typedef logic [3:0] cause_t;

  // Nobody claimed the instruction
  localparam cause_t CAUSE_ILLEGAL = 4'd15;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
/* Core register file, 32 words with x0 tied to zero.
   Two combinational read ports, one synchronous write port. */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      raddr_a,
  input  logic [4:0]      raddr_b,
  input  logic            we,
  input  logic [4:0]      waddr,
  input  rv32_pkg::word_t wdata,
  output rv32_pkg::word_t rdata_a,
  output rv32_pkg::word_t rdata_b
);

  rv32_pkg::word_t regs [32];

  // Reset clears all 32 words
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads zero
  assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- hdl/ext_mul.sv
/* Custom-0 extension that runs a 32-cycle shift-add multiply for the low word.
   Starts on issue when it claims the opcode and pulses done at the end. */
`timescale 1ns/10ps
`default_nettype none

module ext_mul (
  input  logic            clk,
  input  logic            rst,
  input  rv32_pkg::insn_u insn,
  input  rv32_pkg::word_t op_a,
  input  rv32_pkg::word_t op_b,
  input  logic            issue,
  output logic            claim,
  output logic            busy,
  output logic            done,
  output logic            reg_w,
  output rv32_pkg::word_t reg_wdata,
  output logic            exception
);

  logic            start;
  logic            bad_func;
  logic [4:0]      iter;
  rv32_pkg::word_t mcand;
  rv32_pkg::word_t mplier;
  rv32_pkg::word_t acc;

  // Claim depends on the opcode only
  assign claim = (insn.r.opcode == rv32_pkg::OP_CUSTOM0);
  assign start = issue && claim;

  // Busy for 32 iterations and then a one-cycle done
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      iter <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        iter <= '0;
      end else if (busy) begin
        iter <= iter + 5'd1;
        // Product is complete after the last iteration
        if (iter == 5'd31) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  // Multiplicand shifts left, multiplier shifts right
  always_ff @(posedge clk) begin
    if (start) begin
      mcand    <= op_a;
      mplier   <= op_b;
      acc      <= '0;
      bad_func <= (insn.r.funct3 != rmgmt_pkg::F3_MUL) || (insn.r.funct7 != 7'd0);
    end else if (busy) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Result or exception, only in the done cycle
  assign reg_wdata = acc;
  assign reg_w     = done && !bad_func;
  assign exception = done && bad_func;

endmodule

`default_nettype wire

//--- hdl/ext_bitops.sv
/* Custom-1 extension for population count and leading-zero count of rs1.
   Result and done are registered on issue, so it finishes in one cycle. */
`timescale 1ns/10ps
`default_nettype none

module ext_bitops (
  input  logic            clk,
  input  logic            rst,
  input  rv32_pkg::insn_u insn,
  input  rv32_pkg::word_t op_a,
  input  logic            issue,
  output logic            claim,
  output logic            busy,
  output logic            done,
  output logic            reg_w,
  output rv32_pkg::word_t reg_wdata,
  output logic            exception
);

  logic            start;
  logic            bad_func;
  rv32_pkg::word_t popc;
  rv32_pkg::word_t clz;

  assign claim = (insn.r.opcode == rv32_pkg::OP_CUSTOM1);
  assign start = issue && claim;

  // Never stalls and finishes the cycle after issue
  assign busy = 1'b0;

  // Counts of op_a
  // clz scans up so the highest set bit wins and stays 32 for zero
  always_comb begin
    popc = '0;
    clz  = 32'd32;
    for (int i = 0; i < 32; i++) begin
      popc = popc + {31'd0, op_a[i]};
      if (op_a[i]) begin
        clz = 32'd31 - i[31:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // funct3 2..7 are not implemented and raise an exception
  always_ff @(posedge clk) begin
    if (start) begin
      reg_wdata <= (insn.r.funct3 == rmgmt_pkg::F3_CLZ) ? clz : popc;
      bad_func  <= (insn.r.funct3 != rmgmt_pkg::F3_POPC) &&
                   (insn.r.funct3 != rmgmt_pkg::F3_CLZ);
    end
  end

  assign reg_w     = done && !bad_func;
  assign exception = done && bad_func;

endmodule

`default_nettype wire

//--- hdl/rmgmt_arbiter.sv
/* Extension manager between the core and the custom extensions.
   Picks the claiming extension, holds it while it works and routes
   its stall, writeback and exception to the core. */
`timescale 1ns/10ps
`default_nettype none

module rmgmt_arbiter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   issue,
  input  logic [rmgmt_pkg::N_EXT-1:0]            claim,
  input  logic [rmgmt_pkg::N_EXT-1:0]            busy,
  input  logic [rmgmt_pkg::N_EXT-1:0]            done,
  input  logic [rmgmt_pkg::N_EXT-1:0]            reg_w,
  input  rv32_pkg::word_t [rmgmt_pkg::N_EXT-1:0] reg_wdata,
  input  logic [rmgmt_pkg::N_EXT-1:0]            exception,
  output logic                                   ext_claimed,
  output logic                                   ext_busy,
  output logic                                   ext_done,
  output logic                                   ext_reg_w,
  output rv32_pkg::word_t                        ext_wdata,
  output logic                                   ext_exc,
  output rmgmt_pkg::cause_t                      ext_cause
);

  logic [rmgmt_pkg::EXT_BITS-1:0] sel_ext;
  logic [rmgmt_pkg::EXT_BITS-1:0] act_ext;
  logic                           active;

  // Highest claiming index wins
  always_comb begin
    sel_ext = '0;
    for (int i = 0; i < rmgmt_pkg::N_EXT; i++) begin
      if (claim[i]) begin
        sel_ext = i[rmgmt_pkg::EXT_BITS-1:0];
      end
    end
  end

  assign ext_claimed = |claim;

  // Selection is frozen at issue
  // insn may change decode meaning only once the core has finished
  always_ff @(posedge clk) begin
    if (rst) begin
      active  <= 1'b0;
      act_ext <= '0;
    end else if (issue && ext_claimed) begin
      active  <= 1'b1;
      act_ext <= sel_ext;
    end else if (active && done[act_ext]) begin
      active <= 1'b0;
    end
  end

  // Routing to the core
  // Nothing leaks through when no extension is running
  assign ext_busy  = active && busy[act_ext];
  assign ext_done  = active && done[act_ext];
  assign ext_reg_w = active && reg_w[act_ext];
  assign ext_exc   = active && exception[act_ext];
  assign ext_wdata = active ? reg_wdata[act_ext] : '0;

  // Cause is the extension number
  assign ext_cause = active ? rmgmt_pkg::cause_t'(act_ext) : '0;

endmodule

`default_nettype wire

//--- hdl/insn_sequencer.sv
/* Standard core control that takes one instruction per req/ack handshake,
   runs addi and add itself and hands the rest to the extensions. */
`timescale 1ns/10ps
`default_nettype none

module insn_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_req,
  input  rv32_pkg::insn_u   insn,
  input  rv32_pkg::word_t   rdata_a,
  input  rv32_pkg::word_t   rdata_b,
  input  logic              ext_claimed,
  input  logic              ext_busy,
  input  logic              ext_done,
  input  logic              ext_reg_w,
  input  rv32_pkg::word_t   ext_wdata,
  input  logic              ext_exc,
  input  rmgmt_pkg::cause_t ext_cause,
  output logic              insn_ack,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  output rv32_pkg::word_t   op_a,
  output rv32_pkg::word_t   op_b,
  output logic              issue,
  output logic              rf_we,
  output logic [4:0]        rf_waddr,
  output rv32_pkg::word_t   rf_wdata,
  output logic              wb_valid,
  output logic [4:0]        wb_rd,
  output rv32_pkg::word_t   wb_data,
  output logic              exc_valid,
  output rmgmt_pkg::cause_t exc_cause
);

  enum logic [2:0] {IDLE, READ, EXEC, WAIT_EXT, ACK} state, state_next;

  logic            is_addi;
  logic            is_add;
  logic            is_base;
  logic            ext_finish;
  rv32_pkg::word_t imm_sext;
  rv32_pkg::word_t base_result;

  // Decode addi through the I view and add through the R view
  assign is_addi = (insn.i.opcode == rv32_pkg::OP_IMM) && (insn.i.funct3 == rv32_pkg::F3_ADD);
  assign is_add  = (insn.r.opcode == rv32_pkg::OP_REG) && (insn.r.funct3 == rv32_pkg::F3_ADD) &&
                   (insn.r.funct7 == 7'd0);
  assign is_base = is_addi || is_add;

  assign imm_sext    = {{20{insn.i.imm[11]}}, insn.i.imm};
  assign base_result = is_addi ? op_a + imm_sext : op_a + op_b;

  assign rs1 = insn.r.rs1;
  assign rs2 = insn.r.rs2;

  // Extensions start in the read cycle with the latched operands
  assign issue      = (state == READ) && !is_base && ext_claimed;
  assign ext_finish = ext_done && !ext_busy;
  assign insn_ack   = (state == ACK);

  always_comb begin
    state_next = state;
    case (state)
      IDLE:     if (insn_req) state_next = READ;
      // Unclaimed non-base instructions take the EXEC path and trap
      READ:     state_next = (!is_base && ext_claimed) ? WAIT_EXT : EXEC;
      EXEC:     state_next = ACK;
      WAIT_EXT: if (ext_finish) state_next = ACK;
      // Hold ack until the requester lets go
      ACK:      if (!insn_req) state_next = IDLE;
      default:  state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      wb_valid  <= 1'b0;
      exc_valid <= 1'b0;
    end else begin
      state     <= state_next;
      wb_valid  <= ((state == EXEC) && is_base) ||
                   ((state == WAIT_EXT) && ext_finish && ext_reg_w);
      exc_valid <= ((state == EXEC) && !is_base) ||
                   ((state == WAIT_EXT) && ext_finish && ext_exc);
    end
  end

  // Operands sampled as the instruction is accepted
  always_ff @(posedge clk) begin
    if (state == IDLE && insn_req) begin
      op_a <= rdata_a;
      op_b <= rdata_b;
    end
  end

  // Completion payload with zero data for x0
  always_ff @(posedge clk) begin
    if (state == EXEC) begin
      wb_rd     <= insn.r.rd;
      wb_data   <= (insn.r.rd == 5'd0) ? '0 : base_result;
      exc_cause <= rmgmt_pkg::CAUSE_ILLEGAL;
    end else if (state == WAIT_EXT && ext_finish) begin
      wb_rd     <= insn.r.rd;
      wb_data   <= (insn.r.rd == 5'd0) ? '0 : ext_wdata;
      exc_cause <= ext_cause;
    end
  end

  // Register file write lands the cycle after ack rises
  assign rf_we    = wb_valid;
  assign rf_waddr = wb_rd;
  assign rf_wdata = wb_data;

endmodule

`default_nettype wire

//--- hdl/rmgmt_top.sv
/* Top level of the extension-managed core: sequencer, register file,
   extension manager and the multiply and bit-op extensions. */
`timescale 1ns/10ps
`default_nettype none

module rmgmt_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_req,
  input  rv32_pkg::insn_u   insn,
  output logic              insn_ack,
  output logic              wb_valid,
  output logic [4:0]        wb_rd,
  output rv32_pkg::word_t   wb_data,
  output logic              exc_valid,
  output rmgmt_pkg::cause_t exc_cause
);

  // Register file side
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  rv32_pkg::word_t rdata_a;
  rv32_pkg::word_t rdata_b;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  rv32_pkg::word_t rf_wdata;

  // Broadcast to the extensions
  rv32_pkg::word_t op_a;
  rv32_pkg::word_t op_b;
  logic            issue;

  // Per-extension bundles indexed by extension number
  logic [rmgmt_pkg::N_EXT-1:0]            claim;
  logic [rmgmt_pkg::N_EXT-1:0]            busy;
  logic [rmgmt_pkg::N_EXT-1:0]            done;
  logic [rmgmt_pkg::N_EXT-1:0]            reg_w;
  rv32_pkg::word_t [rmgmt_pkg::N_EXT-1:0] reg_wdata;
  logic [rmgmt_pkg::N_EXT-1:0]            exception;

  // Manager back to the core
  logic              ext_claimed;
  logic              ext_busy;
  logic              ext_done;
  logic              ext_reg_w;
  rv32_pkg::word_t   ext_wdata;
  logic              ext_exc;
  rmgmt_pkg::cause_t ext_cause;

  insn_sequencer insn_sequencer_i (
    .clk, .rst, .insn_req, .insn, .rdata_a, .rdata_b,
    .ext_claimed, .ext_busy, .ext_done, .ext_reg_w, .ext_wdata, .ext_exc, .ext_cause,
    .insn_ack, .rs1, .rs2, .op_a, .op_b, .issue, .rf_we, .rf_waddr, .rf_wdata,
    .wb_valid, .wb_rd, .wb_data, .exc_valid, .exc_cause
  );

  reg_file reg_file_i (
    .clk, .rst, .raddr_a(rs1), .raddr_b(rs2),
    .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .rdata_a, .rdata_b
  );

  rmgmt_arbiter rmgmt_arbiter_i (
    .clk, .rst, .issue, .claim, .busy, .done, .reg_w, .reg_wdata, .exception,
    .ext_claimed, .ext_busy, .ext_done, .ext_reg_w, .ext_wdata, .ext_exc, .ext_cause
  );

  ext_mul ext_mul_i (
    .clk, .rst, .insn, .op_a, .op_b, .issue,
    .claim(claim[rmgmt_pkg::EXT_MUL]), .busy(busy[rmgmt_pkg::EXT_MUL]),
    .done(done[rmgmt_pkg::EXT_MUL]), .reg_w(reg_w[rmgmt_pkg::EXT_MUL]),
    .reg_wdata(reg_wdata[rmgmt_pkg::EXT_MUL]), .exception(exception[rmgmt_pkg::EXT_MUL])
  );

  ext_bitops ext_bitops_i (
    .clk, .rst, .insn, .op_a, .issue,
    .claim(claim[rmgmt_pkg::EXT_BITOPS]), .busy(busy[rmgmt_pkg::EXT_BITOPS]),
    .done(done[rmgmt_pkg::EXT_BITOPS]), .reg_w(reg_w[rmgmt_pkg::EXT_BITOPS]),
    .reg_wdata(reg_wdata[rmgmt_pkg::EXT_BITOPS]), .exception(exception[rmgmt_pkg::EXT_BITOPS])
  );

endmodule

`default_nettype wire

//--- dv/rmgmt_tb.sv
/* Testbench for rmgmt_top. Replays dv/rmgmt_stim.txt over the req/ack
   handshake and checks every writeback and exception at ack. */
`timescale 1ns/10ps
`default_nettype none

module rmgmt_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY  = 2;
  // Cycle budget per instruction that covers the 32-iteration multiply
  localparam int INSN_CYCLES  = 50;
  localparam int MAX_INSN     = 64;

  logic              clk;
  logic              rst;
  logic              insn_req;
  rv32_pkg::insn_u   insn;
  logic              insn_ack;
  logic              wb_valid;
  logic [4:0]        wb_rd;
  rv32_pkg::word_t   wb_data;
  logic              exc_valid;
  rmgmt_pkg::cause_t exc_cause;

  // One stimulus entry per instruction
  logic [31:0] stim_insn  [MAX_INSN];
  logic [7:0]  stim_kind  [MAX_INSN];
  logic [4:0]  stim_rd    [MAX_INSN];
  logic [31:0] stim_data  [MAX_INSN];
  logic [3:0]  stim_cause [MAX_INSN];

  int n_insn;
  bit loaded;
  int errors;
  int pulses;

  rmgmt_top rmgmt_top_i (
    .clk, .rst, .insn_req, .insn, .insn_ack, .wb_valid, .wb_rd, .wb_data,
    .exc_valid, .exc_cause
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Every completion pulse seen after reset
  always @(negedge clk) begin
    if (!rst) begin
      if (wb_valid) pulses++;
      if (exc_valid) pulses++;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR %0t ns %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic load_stim();
    int               fd;
    int               fields;
    logic [8*128-1:0] line;
    logic [31:0]      f_insn;
    logic [7:0]       f_kind;
    int               f_rd;
    logic [31:0]      f_data;
    int               f_cause;
    fd = $fopen("dv/rmgmt_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file dv/rmgmt_stim.txt");
      errors++;
    end else begin
      line = '0;
      while ($fgets(line, fd) != 0) begin
        // Comment and blank lines give fewer than five fields
        fields = $sscanf(line, "%h %s %d %h %d", f_insn, f_kind, f_rd, f_data, f_cause);
        if (fields == 5 && n_insn < MAX_INSN) begin
          stim_insn[n_insn]  = f_insn;
          stim_kind[n_insn]  = f_kind;
          stim_rd[n_insn]    = f_rd[4:0];
          stim_data[n_insn]  = f_data;
          stim_cause[n_insn] = f_cause[3:0];
          n_insn++;
        end
        line = '0;
      end
      $fclose(fd);
    end
  endtask

  // One full four-phase handshake with a random late req release
  task automatic run_instruction(input int idx);
    int   cycles;
    int   hold;
    logic exp_wb;
    exp_wb = (stim_kind[idx] == "W");
    @(posedge clk);
    #DRIVE_DELAY;
    insn     = stim_insn[idx];
    insn_req = 1'b1;
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!insn_ack && cycles < INSN_CYCLES);
    assert (insn_ack) else begin
      $display("Instruction %0d (%h) got no ack within %0d cycles", idx, stim_insn[idx],
               INSN_CYCLES);
      errors++;
    end
    if (insn_ack) begin
      assert (wb_valid ^ exc_valid) else begin
        $display("Instruction %0d did not give exactly one completion pulse at ack", idx);
        errors++;
      end
      check_value("wb_valid", 32'(exp_wb), 32'(wb_valid));
      check_value("exc_valid", 32'(!exp_wb), 32'(exc_valid));
      if (exp_wb) begin
        check_value("wb_rd", 32'(stim_rd[idx]), 32'(wb_rd));
        check_value("wb_data", stim_data[idx], wb_data);
      end else begin
        check_value("exc_cause", 32'(stim_cause[idx]), 32'(exc_cause));
      end
      // Multiply has to sit out its busy period first
      if (stim_insn[idx][6:0] == rv32_pkg::OP_CUSTOM0) begin
        assert (cycles > 32) else begin
          $display("Multiply %0d acked after %0d cycles, before its busy period", idx, cycles);
          errors++;
        end
      end
    end
    // Back-pressure with 0 to 3 extra cycles of req still high
    hold = $urandom % 4;
    repeat (hold) begin
      @(negedge clk);
      assert (insn_ack) else begin
        $display("Instruction %0d lost ack while req was still high", idx);
        errors++;
      end
      assert (!wb_valid && !exc_valid) else begin
        $display("Instruction %0d gave a second completion pulse", idx);
        errors++;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    insn_req = 1'b0;
    insn     = '0;
    // Ack falls in the cycle after req is seen low
    @(negedge clk);
    @(negedge clk);
    assert (!insn_ack) else begin
      $display("Instruction %0d kept ack high after req fell", idx);
      errors++;
    end
  endtask

  initial begin
    rst      = 1'b1;
    insn_req = 1'b0;
    insn     = '0;
    errors   = 0;
    pulses   = 0;
    n_insn   = 0;
    loaded   = 1'b0;
    void'($urandom(28));
    load_stim();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    @(negedge clk);
    assert (!insn_ack && !wb_valid && !exc_valid) else begin
      $display("Completion outputs are not low after reset");
      errors++;
    end
    assert (n_insn > 0) else begin
      $display("No instructions were read from the stimulus file");
      errors++;
    end
    for (int i = 0; i < n_insn; i++) begin
      run_instruction(i);
    end
    assert (pulses == n_insn) else begin
      $display("Saw %0d completion pulses for %0d instructions", pulses, n_insn);
      errors++;
    end
    $display("Summary: %0d instructions, %0d errors", n_insn, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized at one instruction budget per stimulus line plus reset
  initial begin
    wait (loaded);
    repeat (n_insn * INSN_CYCLES + RESET_CYCLES) @(posedge clk);
    $display("Watchdog expired, the run did not finish in time");
    $display("Summary: %0d instructions, %0d errors", n_insn, errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/rmgmt_stim.txt
# insn(hex) kind(W writeback, E exception) rd(dec) data(hex) cause(dec)
# data is checked for W lines, cause for E lines
00500093 W 1 00000005 0
FFD00113 W 2 FFFFFFFD 0
7FF00193 W 3 000007FF 0
FFF00213 W 4 FFFFFFFF 0
06400013 W 0 00000000 0
00100513 W 10 00000001 0
002082B3 W 5 00000002 0
00420333 W 6 FFFFFFFE 0
000003B3 W 7 00000000 0
0020840B W 8 FFFFFFF1 0
0000848B W 9 00000000 0
00A1858B W 11 000007FF 0
0042060B W 12 00000001 0
0061868B W 13 FFFFF002 0
0000072B W 14 00000000 0
000207AB W 15 00000020 0
0000182B W 16 00000020 0
000218AB W 17 00000000 0
0005192B W 18 0000001F 0
000509AB W 19 00000001 0
0000D2AB E 5 00000000 1
0220830B E 6 00000000 0
00028A33 W 20 00000002 0
00030AB3 W 21 FFFFFFFE 0
0000007F E 0 00000000 15

//--- rmgmt_top.f
hdl/rv32_pkg.sv
hdl/rmgmt_pkg.sv
hdl/reg_file.sv
hdl/ext_mul.sv
hdl/ext_bitops.sv
hdl/rmgmt_arbiter.sv
hdl/insn_sequencer.sv
hdl/rmgmt_top.sv
dv/rmgmt_tb.sv

//--- Makefile
# Verilator build and run for the rmgmt_top testbench

TOP       ?= rmgmt_tb
FLIST     ?= rmgmt_top.f
VERILATOR ?= verilator
VFLAGS    ?= -j 0
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: TOP FLIST VERILATOR VFLAGS"

test:
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
